// File: verilog/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int ROB_DEPTH = 16;

    typedef logic [XLEN-1:0]                word_t;
    typedef logic [$clog2(ARCH_REGS)-1:0]   arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0]   phys_tag_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]   rob_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    // RV32 major opcodes and funct7 values
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_SUB = 7'b0100000;
    localparam logic [6:0] F7_MUL = 7'b0000001;

    typedef struct packed {
        alu_op_t   op;
        logic      use_imm;
        word_t     imm;
        phys_tag_t dest;
        rob_idx_t  rob;
    } alu_entry_t;

    typedef struct packed {
        phys_tag_t dest;
        rob_idx_t  rob;
    } mul_entry_t;

endpackage

// File: verilog/decode_rename.sv
`timescale 1ns/100ps

module decode_rename (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  ooo_pkg::word_t      in_word,
    output logic                in_ready,
    input  logic                rob_full,
    input  ooo_pkg::rob_idx_t   alloc_idx,
    input  logic                alu_rs_full,
    input  logic                mul_rs_full,
    input  logic                free_valid,
    input  ooo_pkg::phys_tag_t  free_tag,
    output ooo_pkg::phys_tag_t  src1_tag,
    output ooo_pkg::phys_tag_t  src2_tag,
    output logic                alu_dispatch,
    output logic                mul_dispatch,
    output ooo_pkg::alu_entry_t alu_payload,
    output ooo_pkg::mul_entry_t mul_payload,
    output logic                alloc_valid,
    output ooo_pkg::arch_reg_t  alloc_rd,
    output ooo_pkg::phys_tag_t  alloc_new_tag,
    output ooo_pkg::phys_tag_t  alloc_old_tag,
    output logic                alloc_has_dest
);
    import ooo_pkg::*;

    localparam int FL_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FL_W     = $clog2(FL_DEPTH);

    phys_tag_t       rat [ARCH_REGS];
    phys_tag_t       free_list [FL_DEPTH];
    logic [FL_W-1:0] fl_head, fl_tail;
    logic [FL_W:0]   fl_count;

    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    arch_reg_t  rd, rs1, rs2;
    word_t      imm;
    alu_op_t    op;
    logic       supported, is_mul, is_reg, has_dest, pop, target_full;

    function automatic logic [FL_W-1:0] fl_next(logic [FL_W-1:0] p);
        return (p == FL_W'(FL_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign opcode = in_word[6:0];
    assign rd     = in_word[11:7];
    assign funct3 = in_word[14:12];
    assign rs1    = in_word[19:15];
    assign rs2    = in_word[24:20];
    assign funct7 = in_word[31:25];
    assign imm    = {{(XLEN-12){in_word[31]}}, in_word[31:20]};
    assign is_reg = opcode == OP_REG;

    always_comb begin
        op        = ALU_ADD;
        supported = 1'b1;
        is_mul    = 1'b0;
        case (funct3)
            3'b000:  op = (is_reg && funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: supported = 1'b0;
        endcase
        if (is_reg) begin
            if (funct7 == F7_MUL) begin
                is_mul    = funct3 == 3'b000;   // only the low-word mul
                supported = is_mul;
            end else if (funct7 == F7_SUB) begin
                supported = supported && funct3 == 3'b000;
            end else if (funct7 != 7'b0) begin
                supported = 1'b0;
            end
        end else if (opcode != OP_IMM) begin
            supported = 1'b0;
        end
    end

    assign has_dest    = supported && rd != '0;
    assign target_full = is_mul ? mul_rs_full : alu_rs_full;
    assign in_ready    = !rob_full && !target_full && !(has_dest && fl_count == '0);
    assign alloc_valid = in_valid && in_ready;
    assign pop         = alloc_valid && has_dest;

    assign alu_dispatch = alloc_valid && !is_mul;
    assign mul_dispatch = alloc_valid && is_mul;

    // anything unsupported runs as add of tag 0 to tag 0
    assign src1_tag = supported ? rat[rs1] : '0;
    assign src2_tag = (supported && is_reg) ? rat[rs2] : '0;

    assign alloc_rd       = has_dest ? rd : '0;
    assign alloc_new_tag  = has_dest ? free_list[fl_head] : '0;
    assign alloc_old_tag  = rat[rd];
    assign alloc_has_dest = has_dest;

    assign alu_payload = '{op: op, use_imm: supported && !is_reg, imm: imm,
                           dest: alloc_new_tag, rob: alloc_idx};
    assign mul_payload = '{dest: alloc_new_tag, rob: alloc_idx};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= phys_tag_t'(ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (FL_W+1)'(FL_DEPTH);
        end else begin
            if (pop) begin
                rat[rd] <= free_list[fl_head];
                fl_head <= fl_next(fl_head);
            end
            if (free_valid) begin   // old tag of a committed write
                free_list[fl_tail] <= free_tag;
                fl_tail            <= fl_next(fl_tail);
            end
            fl_count <= fl_count + (FL_W+1)'(free_valid) - (FL_W+1)'(pop);
        end
    end

endmodule

// File: verilog/phys_regfile.sv
`timescale 1ns/100ps

module phys_regfile (
    input  logic               clk,
    input  logic               reset,
    input  logic               alu_res_valid,
    input  ooo_pkg::phys_tag_t alu_res_tag,
    input  ooo_pkg::word_t     alu_res_value,
    input  logic               mul_res_valid,
    input  ooo_pkg::phys_tag_t mul_res_tag,
    input  ooo_pkg::word_t     mul_res_value,
    input  ooo_pkg::phys_tag_t src1_tag,
    input  ooo_pkg::phys_tag_t src2_tag,
    output logic               src1_ready,
    output logic               src2_ready,
    input  ooo_pkg::phys_tag_t alu_rd1_tag,
    input  ooo_pkg::phys_tag_t alu_rd2_tag,
    input  ooo_pkg::phys_tag_t mul_rd1_tag,
    input  ooo_pkg::phys_tag_t mul_rd2_tag,
    output ooo_pkg::word_t     alu_rd1_data,
    output ooo_pkg::word_t     alu_rd2_data,
    output ooo_pkg::word_t     mul_rd1_data,
    output ooo_pkg::word_t     mul_rd2_data,
    input  logic               alloc_valid,
    input  ooo_pkg::phys_tag_t alloc_new_tag
);
    import ooo_pkg::*;

    word_t                value [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready;

    function automatic logic bus_writes(phys_tag_t t);
        return (alu_res_valid && alu_res_tag == t) || (mul_res_valid && mul_res_tag == t);
    endfunction

    // bypass so a dispatching entry never misses a same-cycle broadcast
    always_comb begin
        src1_ready = ready[src1_tag] || bus_writes(src1_tag);
        src2_ready = ready[src2_tag] || bus_writes(src2_tag);
    end

    assign alu_rd1_data = value[alu_rd1_tag];
    assign alu_rd2_data = value[alu_rd2_tag];
    assign mul_rd1_data = value[mul_rd1_tag];
    assign mul_rd2_data = value[mul_rd2_tag];

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= '1;
            for (int i = 0; i < PHYS_REGS; i++) begin
                value[i] <= '0;
            end
        end else begin
            // tag 0 stays x0
            if (alu_res_valid && alu_res_tag != '0) begin
                value[alu_res_tag] <= alu_res_value;
                ready[alu_res_tag] <= 1'b1;
            end
            if (mul_res_valid && mul_res_tag != '0) begin
                value[mul_res_tag] <= mul_res_value;
                ready[mul_res_tag] <= 1'b1;
            end
            if (alloc_valid && alloc_new_tag != '0) begin
                ready[alloc_new_tag] <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/reservation_station.sv
`timescale 1ns/100ps

module reservation_station #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               dispatch,
    input  ooo_pkg::phys_tag_t src1_tag,
    input  ooo_pkg::phys_tag_t src2_tag,
    input  logic               src1_ready,
    input  logic               src2_ready,
    input  payload_t           payload,
    output logic               full,
    input  logic               bus0_valid,
    input  ooo_pkg::phys_tag_t bus0_tag,
    input  logic               bus1_valid,
    input  ooo_pkg::phys_tag_t bus1_tag,
    output logic               issue,
    output payload_t           issue_payload,
    output ooo_pkg::phys_tag_t issue_src1_tag,
    output ooo_pkg::phys_tag_t issue_src2_tag
);
    import ooo_pkg::*;

    // slot 0 holds the oldest entry, valid bits stay packed toward it
    logic [DEPTH-1:0] valid, rdy1, rdy2;
    payload_t         pay [DEPTH];
    phys_tag_t        tag1 [DEPTH], tag2 [DEPTH];

    logic [DEPTH-1:0] n_valid, n_rdy1, n_rdy2;
    payload_t         n_pay [DEPTH];
    phys_tag_t        n_tag1 [DEPTH], n_tag2 [DEPTH];
    int               sel;

    function automatic logic woken(phys_tag_t t);
        return (bus0_valid && bus0_tag == t) || (bus1_valid && bus1_tag == t);
    endfunction

    assign full = valid[DEPTH-1];

    always_comb begin
        issue = 1'b0;
        sel   = 0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (valid[i] && rdy1[i] && rdy2[i]) begin
                issue = 1'b1;
                sel   = i;
            end
        end
    end

    assign issue_payload  = pay[sel];
    assign issue_src1_tag = tag1[sel];
    assign issue_src2_tag = tag2[sel];

    always_comb begin
        int  j;
        logic placed;
        placed = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            j = (issue && i >= sel) ? i + 1 : i;    // close the gap left by issue
            if (j < DEPTH) begin
                n_valid[i] = valid[j];
                n_pay[i]   = pay[j];
                n_tag1[i]  = tag1[j];
                n_tag2[i]  = tag2[j];
                n_rdy1[i]  = rdy1[j] || woken(tag1[j]);
                n_rdy2[i]  = rdy2[j] || woken(tag2[j]);
            end else begin
                n_valid[i] = 1'b0;
                n_pay[i]   = pay[i];
                n_tag1[i]  = tag1[i];
                n_tag2[i]  = tag2[i];
                n_rdy1[i]  = 1'b0;
                n_rdy2[i]  = 1'b0;
            end
            if (dispatch && !placed && !n_valid[i]) begin
                placed     = 1'b1;
                n_valid[i] = 1'b1;
                n_pay[i]   = payload;
                n_tag1[i]  = src1_tag;
                n_tag2[i]  = src2_tag;
                n_rdy1[i]  = src1_ready;
                n_rdy2[i]  = src2_ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        pay  <= n_pay;
        tag1 <= n_tag1;
        tag2 <= n_tag2;
        rdy1 <= n_rdy1;
        rdy2 <= n_rdy2;
        if (reset) begin
            valid <= '0;
        end else begin
            valid <= n_valid;
        end
    end

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue,
    input  ooo_pkg::alu_entry_t issue_payload,
    input  ooo_pkg::word_t      op1,
    input  ooo_pkg::word_t      op2,
    output logic                res_valid,
    output ooo_pkg::phys_tag_t  res_tag,
    output ooo_pkg::rob_idx_t   res_rob,
    output ooo_pkg::word_t      res_value
);
    import ooo_pkg::*;

    word_t operand_b, result;

    assign operand_b = issue_payload.use_imm ? issue_payload.imm : op2;

    always_comb begin
        case (issue_payload.op)
            ALU_ADD: result = op1 + operand_b;
            ALU_SUB: result = op1 - operand_b;
            ALU_AND: result = op1 & operand_b;
            ALU_OR:  result = op1 | operand_b;
            ALU_XOR: result = op1 ^ operand_b;
            ALU_SLT: result = word_t'($signed(op1) < $signed(operand_b));
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        res_tag   <= issue_payload.dest;
        res_rob   <= issue_payload.rob;
        res_value <= result;
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue;
        end
    end

endmodule

// File: verilog/mul_unit.sv
`timescale 1ns/100ps

module mul_unit #(
    parameter int MUL_STAGES = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue,
    input  ooo_pkg::mul_entry_t issue_payload,
    input  ooo_pkg::word_t      op1,
    input  ooo_pkg::word_t      op2,
    output logic                res_valid,
    output ooo_pkg::phys_tag_t  res_tag,
    output ooo_pkg::rob_idx_t   res_rob,
    output ooo_pkg::word_t      res_value
);
    import ooo_pkg::*;

    logic [MUL_STAGES-1:0] vld;
    word_t                 prod_q [MUL_STAGES];
    phys_tag_t             tag_q [MUL_STAGES];
    rob_idx_t              rob_q [MUL_STAGES];

    always_ff @(posedge clk) begin
        prod_q[0] <= op1 * op2;     // low word only
        tag_q[0]  <= issue_payload.dest;
        rob_q[0]  <= issue_payload.rob;
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
            tag_q[i]  <= tag_q[i-1];
            rob_q[i]  <= rob_q[i-1];
        end
        if (reset) begin
            vld <= '0;
        end else begin
            vld[0] <= issue;
            for (int i = 1; i < MUL_STAGES; i++) begin
                vld[i] <= vld[i-1];
            end
        end
    end

    assign res_valid = vld[MUL_STAGES-1];
    assign res_tag   = tag_q[MUL_STAGES-1];
    assign res_rob   = rob_q[MUL_STAGES-1];
    assign res_value = prod_q[MUL_STAGES-1];

endmodule

// File: verilog/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer #(
    parameter int DEPTH = ooo_pkg::ROB_DEPTH
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               alloc_valid,
    input  ooo_pkg::arch_reg_t alloc_rd,
    input  ooo_pkg::phys_tag_t alloc_old_tag,
    input  logic               alloc_has_dest,
    output logic               rob_full,
    output ooo_pkg::rob_idx_t  alloc_idx,
    input  logic               alu_res_valid,
    input  ooo_pkg::rob_idx_t  alu_res_rob,
    input  ooo_pkg::word_t     alu_res_value,
    input  logic               mul_res_valid,
    input  ooo_pkg::rob_idx_t  mul_res_rob,
    input  ooo_pkg::word_t     mul_res_value,
    output logic               commit_valid,
    output ooo_pkg::arch_reg_t commit_rd,
    output ooo_pkg::word_t     commit_value,
    output logic               free_valid,
    output ooo_pkg::phys_tag_t free_tag
);
    import ooo_pkg::*;

    localparam int CW = $clog2(DEPTH + 1);

    rob_idx_t         head, tail;
    logic [CW-1:0]    count;
    logic [DEPTH-1:0] done, dest_q;
    arch_reg_t        rd_q [DEPTH];
    phys_tag_t        old_q [DEPTH];
    word_t            value_q [DEPTH];

    function automatic rob_idx_t bump(rob_idx_t p);
        return (p == rob_idx_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign rob_full  = count == CW'(DEPTH);
    assign alloc_idx = tail;

    assign commit_valid = count != '0 && done[head];
    assign commit_rd    = rd_q[head];
    assign commit_value = dest_q[head] ? value_q[head] : '0;  // x0 reads as zero
    assign free_valid   = commit_valid && dest_q[head];
    assign free_tag     = old_q[head];

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            rd_q[tail]   <= alloc_rd;
            old_q[tail]  <= alloc_old_tag;
            dest_q[tail] <= alloc_has_dest;
        end
        if (alu_res_valid) value_q[alu_res_rob] <= alu_res_value;
        if (mul_res_valid) value_q[mul_res_rob] <= mul_res_value;

        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc_valid) begin
                done[tail] <= 1'b0;
                tail       <= bump(tail);
            end
            if (alu_res_valid) done[alu_res_rob] <= 1'b1;
            if (mul_res_valid) done[mul_res_rob] <= 1'b1;
            if (commit_valid) head <= bump(head);
            count <= count + CW'(alloc_valid) - CW'(commit_valid);
        end
    end

endmodule

// File: verilog/ooo_core.sv
`timescale 1ns/100ps

module ooo_core #(
    parameter int ALU_RS_DEPTH = 4,
    parameter int MUL_RS_DEPTH = 4,
    parameter int MUL_STAGES   = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  ooo_pkg::word_t     in_word,
    output logic               in_ready,
    output logic               commit_valid,
    output ooo_pkg::arch_reg_t commit_rd,
    output ooo_pkg::word_t     commit_value
);
    import ooo_pkg::*;

    phys_tag_t  src1_tag, src2_tag;
    logic       src1_ready, src2_ready;
    logic       alu_dispatch, mul_dispatch;
    alu_entry_t alu_payload, alu_issue_payload;
    mul_entry_t mul_payload, mul_issue_payload;
    logic       alu_rs_full, mul_rs_full, rob_full;

    logic       alloc_valid, alloc_has_dest;
    arch_reg_t  alloc_rd;
    phys_tag_t  alloc_new_tag, alloc_old_tag;
    rob_idx_t   alloc_idx;
    logic       free_valid;
    phys_tag_t  free_tag;

    logic       alu_issue, mul_issue;
    phys_tag_t  alu_iss_tag1, alu_iss_tag2, mul_iss_tag1, mul_iss_tag2;
    word_t      alu_op1, alu_op2, mul_op1, mul_op2;

    // result buses
    logic       alu_res_valid, mul_res_valid;
    phys_tag_t  alu_res_tag, mul_res_tag;
    rob_idx_t   alu_res_rob, mul_res_rob;
    word_t      alu_res_value, mul_res_value;

    decode_rename u_decode (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_word(in_word), .in_ready(in_ready),
        .rob_full(rob_full), .alloc_idx(alloc_idx),
        .alu_rs_full(alu_rs_full), .mul_rs_full(mul_rs_full),
        .free_valid(free_valid), .free_tag(free_tag),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .alu_dispatch(alu_dispatch), .mul_dispatch(mul_dispatch),
        .alu_payload(alu_payload), .mul_payload(mul_payload),
        .alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
        .alloc_new_tag(alloc_new_tag), .alloc_old_tag(alloc_old_tag),
        .alloc_has_dest(alloc_has_dest)
    );

    phys_regfile u_prf (
        .clk(clk), .reset(reset),
        .alu_res_valid(alu_res_valid), .alu_res_tag(alu_res_tag),
        .alu_res_value(alu_res_value),
        .mul_res_valid(mul_res_valid), .mul_res_tag(mul_res_tag),
        .mul_res_value(mul_res_value),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .alu_rd1_tag(alu_iss_tag1), .alu_rd2_tag(alu_iss_tag2),
        .mul_rd1_tag(mul_iss_tag1), .mul_rd2_tag(mul_iss_tag2),
        .alu_rd1_data(alu_op1), .alu_rd2_data(alu_op2),
        .mul_rd1_data(mul_op1), .mul_rd2_data(mul_op2),
        .alloc_valid(alloc_valid), .alloc_new_tag(alloc_new_tag)
    );

    reservation_station #(.payload_t(alu_entry_t), .DEPTH(ALU_RS_DEPTH)) u_alu_rs (
        .clk(clk), .reset(reset), .dispatch(alu_dispatch),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .payload(alu_payload), .full(alu_rs_full),
        .bus0_valid(alu_res_valid), .bus0_tag(alu_res_tag),
        .bus1_valid(mul_res_valid), .bus1_tag(mul_res_tag),
        .issue(alu_issue), .issue_payload(alu_issue_payload),
        .issue_src1_tag(alu_iss_tag1), .issue_src2_tag(alu_iss_tag2)
    );

    reservation_station #(.payload_t(mul_entry_t), .DEPTH(MUL_RS_DEPTH)) u_mul_rs (
        .clk(clk), .reset(reset), .dispatch(mul_dispatch),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .payload(mul_payload), .full(mul_rs_full),
        .bus0_valid(alu_res_valid), .bus0_tag(alu_res_tag),
        .bus1_valid(mul_res_valid), .bus1_tag(mul_res_tag),
        .issue(mul_issue), .issue_payload(mul_issue_payload),
        .issue_src1_tag(mul_iss_tag1), .issue_src2_tag(mul_iss_tag2)
    );

    alu_unit u_alu (
        .clk(clk), .reset(reset),
        .issue(alu_issue), .issue_payload(alu_issue_payload),
        .op1(alu_op1), .op2(alu_op2),
        .res_valid(alu_res_valid), .res_tag(alu_res_tag),
        .res_rob(alu_res_rob), .res_value(alu_res_value)
    );

    mul_unit #(.MUL_STAGES(MUL_STAGES)) u_mul (
        .clk(clk), .reset(reset),
        .issue(mul_issue), .issue_payload(mul_issue_payload),
        .op1(mul_op1), .op2(mul_op2),
        .res_valid(mul_res_valid), .res_tag(mul_res_tag),
        .res_rob(mul_res_rob), .res_value(mul_res_value)
    );

    reorder_buffer #(.DEPTH(ROB_DEPTH)) u_rob (
        .clk(clk), .reset(reset),
        .alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
        .alloc_old_tag(alloc_old_tag), .alloc_has_dest(alloc_has_dest),
        .rob_full(rob_full), .alloc_idx(alloc_idx),
        .alu_res_valid(alu_res_valid), .alu_res_rob(alu_res_rob),
        .alu_res_value(alu_res_value),
        .mul_res_valid(mul_res_valid), .mul_res_rob(mul_res_rob),
        .mul_res_value(mul_res_value),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value),
        .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

// File: sim/ooo_core_tb.sv
`timescale 1ns/100ps

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int RESET_CYCLES = 8;

    logic      clk;
    logic      reset;
    logic      in_valid;
    word_t     in_word;
    logic      in_ready;
    logic      commit_valid;
    arch_reg_t commit_rd;
    word_t     commit_value;

    word_t     model_regs [ARCH_REGS];
    arch_reg_t exp_rd_q [$];
    word_t     exp_val_q [$];
    int        sent_count;
    int        cycles;
    int        seed;

    ooo_core #(.ALU_RS_DEPTH(4), .MUL_RS_DEPTH(4), .MUL_STAGES(3)) dut (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_word(in_word), .in_ready(in_ready),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_reg(input string name, input arch_reg_t got, input arch_reg_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic word_t r_type(logic [6:0] f7, arch_reg_t rs2, arch_reg_t rs1,
                                     logic [2:0] f3, arch_reg_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, arch_reg_t rs1, logic [2:0] f3,
                                     arch_reg_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // architectural reference applied in program order
    task automatic model_apply(input word_t w, output arch_reg_t rd_exp, output word_t val_exp);
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        word_t      a, b, imm, res;
        logic       ok;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        ok  = 1'b1;
        res = '0;
        if (opc == 7'b0110011 && f7 == 7'h00) begin
            case (f3)
                3'd0: res = a + b;
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd6: res = a | b;
                3'd7: res = a & b;
                default: ok = 1'b0;
            endcase
        end else if (opc == 7'b0110011 && f7 == 7'h20 && f3 == 3'd0) begin
            res = a - b;
        end else if (opc == 7'b0110011 && f7 == 7'h01 && f3 == 3'd0) begin
            res = a * b;
        end else if (opc == 7'b0010011) begin
            case (f3)
                3'd0: res = a + imm;
                3'd2: res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                3'd4: res = a ^ imm;
                3'd6: res = a | imm;
                3'd7: res = a & imm;
                default: ok = 1'b0;
            endcase
        end else begin
            ok = 1'b0;
        end
        if (!ok || w[11:7] == 5'd0) begin   // nop or x0 write
            rd_exp  = '0;
            val_exp = '0;
        end else begin
            model_regs[w[11:7]] = res;
            rd_exp  = w[11:7];
            val_exp = res;
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the transfer edge
    task automatic send(input word_t w);
        arch_reg_t rd_exp;
        word_t     val_exp;
        in_valid = 1'b1;
        in_word  = w;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        model_apply(w, rd_exp, val_exp);
        exp_rd_q.push_back(rd_exp);
        exp_val_q.push_back(val_exp);
        sent_count++;
    endtask

    task automatic wait_drain();
        while (exp_rd_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic test_idle();
        repeat (20) begin
            @(negedge clk);
            check_flag("in_ready", in_ready, 1'b1);
            check_flag("commit_valid", commit_valid, 1'b0);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_independent_alu();
        send(i_type(5, 0, 3'd0, 1));
        send(i_type(-7, 0, 3'd0, 2));
        send(r_type(7'h00, 2, 1, 3'd0, 3));
        send(r_type(7'h20, 2, 1, 3'd0, 4));     // 5 - (-7)
        send(r_type(7'h20, 1, 2, 3'd0, 5));     // goes negative
        send(r_type(7'h00, 1, 2, 3'd2, 6));     // slt -7 < 5
        send(r_type(7'h00, 2, 1, 3'd2, 7));
        send(i_type(-3, 2, 3'd2, 8));
        send(r_type(7'h00, 2, 1, 3'd7, 9));
        send(r_type(7'h00, 2, 1, 3'd6, 10));
        send(r_type(7'h00, 2, 1, 3'd4, 11));
        send(i_type(12'h0f0, 2, 3'd7, 12));
        send(i_type(12'h801, 1, 3'd6, 13));
        send(i_type(-1, 1, 3'd4, 14));
        wait_drain();
    endtask

    task automatic test_dependent_chain();
        send(i_type(1, 0, 3'd0, 8));
        for (int i = 0; i < 8; i++) begin
            send(r_type(7'h00, 8, 8, 3'd0, 8));
            send(i_type(3, 8, 3'd0, 8));
            send(r_type(7'h20, 1, 8, 3'd0, 8));
        end
        send(r_type(7'h01, 8, 8, 3'd0, 8));
        send(i_type(-1, 8, 3'd4, 8));
        wait_drain();
    endtask

    task automatic test_mul_order();
        send(i_type(1234, 0, 3'd0, 9));
        send(i_type(-56, 0, 3'd0, 10));
        wait_drain();
        send(r_type(7'h01, 10, 9, 3'd0, 11));
        send(i_type(7, 0, 3'd0, 12));
        send(r_type(7'h00, 10, 9, 3'd4, 13));
        send(r_type(7'h00, 9, 10, 3'd0, 14));
        send(r_type(7'h01, 11, 11, 3'd0, 15));  // waits on the first mul
        send(i_type(1, 12, 3'd0, 16));
        wait_drain();
    endtask

    task automatic test_x0_and_nop();
        send(i_type(99, 0, 3'd0, 0));
        send(r_type(7'h00, 10, 9, 3'd0, 0));
        send(r_type(7'h00, 9, 9, 3'd1, 17));    // sll
        send(32'hffff_ffff);
        send(32'h0000_0073);
        send(r_type(7'h00, 0, 0, 3'd0, 18));
        send(i_type(5, 0, 3'd0, 19));
        send(r_type(7'h00, 19, 0, 3'd6, 20));
        wait_drain();
    endtask

    task automatic test_random();
        int          kind;
        arch_reg_t   rd, rs1, rs2;
        logic [11:0] imm;
        logic [2:0]  f3;
        for (int n = 0; n < 200; n++) begin
            kind = $unsigned($random(seed)) % 10;
            rd   = arch_reg_t'($unsigned($random(seed)) % 5);
            rs1  = arch_reg_t'($unsigned($random(seed)) % 5);
            rs2  = arch_reg_t'($unsigned($random(seed)) % 5);
            imm  = $random(seed);
            f3   = ($unsigned($random(seed)) % 3 == 0) ? 3'd4 : 3'd6 + (imm[0] ? 3'd1 : 3'd0);
            case (kind)
                0:       send(r_type(7'h00, rs2, rs1, 3'd0, rd));
                1:       send(r_type(7'h20, rs2, rs1, 3'd0, rd));
                2:       send(r_type(7'h00, rs2, rs1, 3'd2, rd));
                3:       send(r_type(7'h00, rs2, rs1, f3, rd));
                4, 5:    send(r_type(7'h01, rs2, rs1, 3'd0, rd));
                6:       send(i_type(imm, rs1, 3'd0, rd));
                7:       send(i_type(imm, rs1, 3'd2, rd));
                8:       send(i_type(imm, rs1, f3, rd));
                default: send(r_type(7'h00, rs2, rs1, 3'd5, rd));   // srl, not supported
            endcase
        end
        wait_drain();
    endtask

    // commit monitor
    initial begin
        arch_reg_t rd_exp;
        word_t     val_exp;
        forever begin
            @(negedge clk);
            if (!reset && commit_valid) begin
                if (exp_rd_q.size() == 0) begin
                    stop_on_error("a commit appeared with no instruction outstanding");
                end else begin
                    rd_exp  = exp_rd_q.pop_front();
                    val_exp = exp_val_q.pop_front();
                    check_reg("commit_rd", commit_rd, rd_exp);
                    check_word("commit_value", commit_value, val_exp);
                end
            end
        end
    end

    // limit grows with every accepted instruction
    initial begin
        cycles = 0;
        while (cycles <= 50 * sent_count + 200 + RESET_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        stop_on_error("the core stopped making progress before all instructions committed");
    end

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_word    = '0;
        sent_count = 0;
        seed       = 23;
        for (int i = 0; i < ARCH_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        test_idle();
        test_independent_alu();
        test_dependent_chain();
        test_mul_order();
        test_x0_and_nop();
        test_random();

        $display("Test passed");
        $finish;
    end

endmodule

// File: ooo_core.f
verilog/ooo_pkg.sv
verilog/decode_rename.sv
verilog/phys_regfile.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
sim/ooo_core_tb.sv
